//--- Bender.yml
package:
  name: rv_core

sources:
  - src/rv_pkg.sv
  - src/rv_ifaces.sv
  - src/rv_fetch.sv
  - src/rv_decode.sv
  - src/rv_regfile.sv
  - src/rv_alu_unit.sv
  - src/rv_csr_unit.sv
  - src/rv_retire.sv
  - src/rv_core.sv
  - target: test
    files:
      - tests/rv_core_tb.sv

//--- rv_core.f
src/rv_pkg.sv
src/rv_ifaces.sv
src/rv_fetch.sv
src/rv_decode.sv
src/rv_regfile.sv
src/rv_alu_unit.sv
src/rv_csr_unit.sv
src/rv_retire.sv
src/rv_core.sv
tests/rv_core_tb.sv

//--- src/rv_alu_unit.sv
`timescale 1ns/1ps

module rv_alu_unit (
	issue_if.unit      issue,
	result_if.producer res
);
	import rv_pkg::*;

	logic  active;
	xlen_t a, b, imm, pc;
	xlen_t data;
	logic  taken;
	xlen_t target;

	assign active = issue.valid && issue.uop.unit == unit_alu;
	assign a      = issue.rs1_val;
	assign b      = issue.rs2_val;
	assign imm    = issue.uop.imm;
	assign pc     = issue.pc;

	always_comb begin
		data   = '0;
		taken  = 1'b0;
		// pc relative unless jalr
		target = pc + imm;
		case (issue.uop.op)
			op_lui:   data = imm;
			op_auipc: data = pc + imm;
			op_addi:  data = a + imm;
			op_andi:  data = a & imm;
			op_ori:   data = a | imm;
			op_xori:  data = a ^ imm;
			op_add:   data = a + b;
			op_sub:   data = a - b;
			op_and:   data = a & b;
			op_or:    data = a | b;
			op_xor:   data = a ^ b;
			// branch compares, blt and bge signed
			op_beq:   taken = (a == b);
			op_bne:   taken = (a != b);
			op_blt:   taken = ($signed(a) < $signed(b));
			op_bge:   taken = ($signed(a) >= $signed(b));
			op_jal: begin
				data  = pc + 64'd4;
				taken = 1'b1;
			end
			op_jalr: begin
				data   = pc + 64'd4;
				taken  = 1'b1;
				target = (a + imm) & ~64'd1;
			end
			default: ;
		endcase
	end

	assign res.valid    = active;
	assign res.wen      = active && issue.uop.wen;
	assign res.rd       = issue.uop.rd;
	assign res.data     = data;
	assign res.redirect = active && taken;
	assign res.target   = target;

endmodule

//--- src/rv_core.sv
`timescale 1ns/1ps

module rv_core #(
	parameter rv_pkg::xlen_t reset_pc = 64'h8000_0000
) (
	input  logic             clk,
	input  logic             rst_n,
	output rv_pkg::xlen_t    inst_addr,
	input  rv_pkg::inst_t    inst,
	output logic             retire_valid,
	output rv_pkg::xlen_t    retire_pc,
	output logic             retire_wen,
	output rv_pkg::reg_idx_t retire_rd,
	output rv_pkg::xlen_t    retire_data
);
	import rv_pkg::*;

	//****************************************
	// stage wiring
	//****************************************

	logic     ex_valid, redirect, rf_wen;
	xlen_t    ex_pc, redirect_pc, rs1_data, rs2_data, rf_wdata;
	inst_t    ex_inst;
	reg_idx_t rs1_idx, rs2_idx, rf_rd;

	issue_if  issue ();
	result_if alu_res ();
	result_if csr_res ();

	// fetch and the single pipeline register
	rv_fetch #(.reset_pc(reset_pc)) ifu (.clk, .rst_n, .redirect, .redirect_pc,
		.inst_addr, .inst, .ex_valid, .ex_pc, .ex_inst);

	rv_decode idu (.ex_valid, .ex_pc, .ex_inst, .rs1_idx, .rs2_idx,
		.rs1_data, .rs2_data, .issue(issue.issuer));

	rv_regfile gpr (.clk, .rst_n, .rs1_idx, .rs2_idx, .rs1_data, .rs2_data,
		.wen(rf_wen), .rd(rf_rd), .wdata(rf_wdata));

	// two execute units side by side
	rv_alu_unit alu (.issue(issue.unit), .res(alu_res.producer));
	rv_csr_unit csru (.clk, .rst_n, .issue(issue.unit), .res(csr_res.producer));

	// write back and difftest report
	rv_retire wbu (.alu_res(alu_res.consumer), .csr_res(csr_res.consumer), .ex_pc,
		.rf_wen, .rf_rd, .rf_wdata, .redirect, .redirect_pc, .retire_valid,
		.retire_pc, .retire_wen, .retire_rd, .retire_data);

endmodule

//--- src/rv_csr_unit.sv
`timescale 1ns/1ps

module rv_csr_unit (
	input  logic       clk,
	input  logic       rst_n,
	issue_if.unit      issue,
	result_if.producer res
);
	import rv_pkg::*;

	// mstatus interrupt enable bits
	localparam int mie_bit  = 3;
	localparam int mpie_bit = 7;

	xlen_t     mstatus_q, mtvec_q, mepc_q, mcause_q;
	logic      active, is_rw, is_trap, is_mret;
	csr_addr_t addr;
	xlen_t     old_val, new_val, cause, target;

	assign active  = issue.valid && issue.uop.unit == unit_csr;
	assign addr    = issue.uop.csr;
	assign is_rw   = active && (issue.uop.op == op_csrrw || issue.uop.op == op_csrrs);
	assign is_trap = active && (issue.uop.op == op_ecall || issue.uop.op == op_illegal);
	assign is_mret = active && issue.uop.op == op_mret;
	assign cause   = (issue.uop.op == op_ecall) ? cause_ecall_m : cause_illegal;

	// csr read, unknown addresses give zero
	always_comb begin
		case (addr)
			csr_mstatus: old_val = mstatus_q;
			csr_mtvec:   old_val = mtvec_q;
			csr_mepc:    old_val = mepc_q;
			csr_mcause:  old_val = mcause_q;
			default:     old_val = '0;
		endcase
	end

	// csrrw replaces, csrrs sets bits
	assign new_val = (issue.uop.op == op_csrrw) ? issue.rs1_val : old_val | issue.rs1_val;

	//****************************************
	// csr state
	//****************************************

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mstatus_q <= mstatus_reset;
			mtvec_q   <= '0;
			mepc_q    <= '0;
			mcause_q  <= '0;
		end else if (is_trap) begin
			mepc_q              <= issue.pc;
			mcause_q            <= cause;
			mstatus_q[mpie_bit] <= mstatus_q[mie_bit];
			mstatus_q[mie_bit]  <= 1'b0;
		end else if (is_mret) begin
			mstatus_q[mie_bit]  <= mstatus_q[mpie_bit];
			mstatus_q[mpie_bit] <= 1'b1;
		end else if (is_rw) begin
			case (addr)
				csr_mstatus: mstatus_q <= new_val;
				csr_mtvec:   mtvec_q   <= new_val;
				csr_mepc:    mepc_q    <= new_val;
				csr_mcause:  mcause_q  <= new_val;
				default: ;
			endcase
		end
	end

	// trap vector is direct mode only
	assign target = is_mret ? {mepc_q[63:2], 2'b00} : {mtvec_q[63:2], 2'b00};

	assign res.valid    = active;
	assign res.wen      = is_rw && issue.uop.wen;
	assign res.rd       = issue.uop.rd;
	assign res.data     = old_val;
	assign res.redirect = is_trap || is_mret;
	assign res.target   = target;

	// mtvec or mepc already word aligned when it feeds a redirect
	target_aligned: assert property (@(posedge clk) disable iff (!rst_n)
		(is_trap || is_mret) |-> (is_mret ? mepc_q[1:0] : mtvec_q[1:0]) == 2'b00);

endmodule

//--- src/rv_decode.sv
`timescale 1ns/1ps

module rv_decode (
	input  logic             ex_valid,
	input  rv_pkg::xlen_t    ex_pc,
	input  rv_pkg::inst_t    ex_inst,
	output rv_pkg::reg_idx_t rs1_idx,
	output rv_pkg::reg_idx_t rs2_idx,
	input  rv_pkg::xlen_t    rs1_data,
	input  rv_pkg::xlen_t    rs2_data,
	issue_if.issuer          issue
);
	import rv_pkg::*;

	// full encodings of the system ops
	localparam inst_t inst_ecall = 32'h0000_0073;
	localparam inst_t inst_mret  = 32'h3020_0073;

	opcode_t    opc;
	logic [2:0] funct3;
	logic [6:0] funct7;
	xlen_t      imm_i, imm_b, imm_u, imm_j;
	uop_t       uop;

	assign opc    = ex_inst[6:0];
	assign funct3 = ex_inst[14:12];
	assign funct7 = ex_inst[31:25];

	// immediates, store format not needed
	assign imm_i = {{52{ex_inst[31]}}, ex_inst[31:20]};
	assign imm_b = {{51{ex_inst[31]}}, ex_inst[31], ex_inst[7], ex_inst[30:25],
		ex_inst[11:8], 1'b0};
	assign imm_u = {{32{ex_inst[31]}}, ex_inst[31:12], 12'b0};
	assign imm_j = {{43{ex_inst[31]}}, ex_inst[31], ex_inst[19:12], ex_inst[20],
		ex_inst[30:21], 1'b0};

	always_comb begin
		uop     = '0;
		uop.op  = op_illegal;
		uop.rd  = ex_inst[11:7];
		uop.rs1 = ex_inst[19:15];
		uop.rs2 = ex_inst[24:20];
		uop.csr = ex_inst[31:20];
		case (opc)
			opc_lui: begin
				uop.op  = op_lui;
				uop.imm = imm_u;
			end
			opc_auipc: begin
				uop.op  = op_auipc;
				uop.imm = imm_u;
			end
			opc_jal: begin
				uop.op  = op_jal;
				uop.imm = imm_j;
			end
			opc_jalr: begin
				if (funct3 == 3'b000) uop.op = op_jalr;
				uop.imm = imm_i;
			end
			opc_branch: begin
				uop.imm = imm_b;
				case (funct3)
					3'b000: uop.op = op_beq;
					3'b001: uop.op = op_bne;
					3'b100: uop.op = op_blt;
					3'b101: uop.op = op_bge;
					default: ;
				endcase
			end
			opc_op_imm: begin
				uop.imm = imm_i;
				case (funct3)
					3'b000: uop.op = op_addi;
					3'b111: uop.op = op_andi;
					3'b110: uop.op = op_ori;
					3'b100: uop.op = op_xori;
					default: ;
				endcase
			end
			opc_op: begin
				if (funct7 == 7'b0000000) begin
					case (funct3)
						3'b000: uop.op = op_add;
						3'b111: uop.op = op_and;
						3'b110: uop.op = op_or;
						3'b100: uop.op = op_xor;
						default: ;
					endcase
				end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
					uop.op = op_sub;
				end
			end
			opc_system: begin
				if (funct3 == 3'b001) uop.op = op_csrrw;
				else if (funct3 == 3'b010) uop.op = op_csrrs;
				else if (ex_inst == inst_ecall) uop.op = op_ecall;
				else if (ex_inst == inst_mret) uop.op = op_mret;
			end
			default: ;
		endcase

		// routing and rd write from the final op
		case (uop.op)
			op_beq, op_bne, op_blt, op_bge: uop.wen = 1'b0;
			op_ecall, op_mret, op_illegal: begin
				uop.wen  = 1'b0;
				uop.unit = unit_csr;
			end
			op_csrrw, op_csrrs: begin
				uop.wen  = 1'b1;
				uop.unit = unit_csr;
			end
			default: uop.wen = 1'b1;
		endcase
	end

	// register read, ports indexed straight from the encoding
	assign rs1_idx = uop.rs1;
	assign rs2_idx = uop.rs2;

	assign issue.valid   = ex_valid;
	assign issue.pc      = ex_pc;
	assign issue.uop     = uop;
	assign issue.rs1_val = rs1_data;
	assign issue.rs2_val = rs2_data;

endmodule

//--- src/rv_fetch.sv
`timescale 1ns/1ps

module rv_fetch #(
	parameter rv_pkg::xlen_t reset_pc = 64'h0
) (
	input  logic          clk,
	input  logic          rst_n,
	input  logic          redirect,
	input  rv_pkg::xlen_t redirect_pc,
	output rv_pkg::xlen_t inst_addr,
	input  rv_pkg::inst_t inst,
	output logic          ex_valid,
	output rv_pkg::xlen_t ex_pc,
	output rv_pkg::inst_t ex_inst
);
	import rv_pkg::*;

	xlen_t pc_q;
	xlen_t pc_d;

	// redirect wins over sequential fetch
	assign pc_d = redirect ? redirect_pc : pc_q + 64'd4;

	// instruction port answers in the same cycle
	assign inst_addr = pc_q;

	// pc and stage valid
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc_q     <= reset_pc;
			ex_valid <= 1'b0;
		end else begin
			pc_q     <= pc_d;
			// younger fetch is dropped on redirect
			ex_valid <= !redirect;
		end
	end

	// fetch to execute payload
	always_ff @(posedge clk) begin
		ex_pc   <= pc_q;
		ex_inst <= inst;
	end

	// all redirect sources deliver word aligned targets
	pc_aligned: assert property (@(posedge clk) disable iff (!rst_n) pc_q[1:0] == 2'b00);

endmodule

//--- src/rv_ifaces.sv
`timescale 1ns/1ps

// decoded instruction plus operands, decode to both units
interface issue_if;
	import rv_pkg::*;

	logic  valid;
	xlen_t pc;
	uop_t  uop;
	xlen_t rs1_val;
	xlen_t rs2_val;

	modport issuer (output valid, pc, uop, rs1_val, rs2_val);
	modport unit   (input  valid, pc, uop, rs1_val, rs2_val);
endinterface

// one unit's outcome for the current instruction
interface result_if;
	import rv_pkg::*;

	logic     valid;
	logic     wen;
	reg_idx_t rd;
	xlen_t    data;
	// control transfer request
	logic     redirect;
	xlen_t    target;

	modport producer (output valid, wen, rd, data, redirect, target);
	modport consumer (input  valid, wen, rd, data, redirect, target);
endinterface

//--- src/rv_pkg.sv
package rv_pkg;

	//****************************************
	// basic word types
	//****************************************

	// data and address word
	typedef logic [63:0] xlen_t;
	// raw instruction word
	typedef logic [31:0] inst_t;
	// general register index
	typedef logic [4:0] reg_idx_t;
	// csr address field
	typedef logic [11:0] csr_addr_t;
	// major opcode field
	typedef logic [6:0] opcode_t;

	// major opcodes of the supported subset
	localparam opcode_t opc_lui    = 7'b0110111;
	localparam opcode_t opc_auipc  = 7'b0010111;
	localparam opcode_t opc_jal    = 7'b1101111;
	localparam opcode_t opc_jalr   = 7'b1100111;
	localparam opcode_t opc_branch = 7'b1100011;
	localparam opcode_t opc_op_imm = 7'b0010011;
	localparam opcode_t opc_op     = 7'b0110011;
	localparam opcode_t opc_system = 7'b1110011;

	//****************************************
	// micro-op
	//****************************************

	typedef enum logic [4:0] {
		op_lui, op_auipc,
		op_addi, op_andi, op_ori, op_xori,
		op_add, op_sub, op_and, op_or, op_xor,
		op_beq, op_bne, op_blt, op_bge,
		op_jal, op_jalr,
		op_csrrw, op_csrrs,
		op_ecall, op_mret,
		op_illegal
	} op_e;

	// executing unit
	typedef enum logic {
		unit_alu,
		unit_csr
	} unit_e;

	typedef struct packed {
		op_e       op;
		unit_e     unit;
		reg_idx_t  rd;
		reg_idx_t  rs1;
		reg_idx_t  rs2;
		logic      wen;   // writes rd
		xlen_t     imm;   // already sign extended
		csr_addr_t csr;
	} uop_t;

	//****************************************
	// machine csr space
	//****************************************

	localparam csr_addr_t csr_mstatus = 12'h300;
	localparam csr_addr_t csr_mtvec   = 12'h305;
	localparam csr_addr_t csr_mepc    = 12'h341;
	localparam csr_addr_t csr_mcause  = 12'h342;

	// trap causes
	localparam xlen_t cause_illegal = 64'd2;
	localparam xlen_t cause_ecall_m = 64'd11;

	// sxl and uxl at 64 bit, mpp at machine
	localparam xlen_t mstatus_reset = 64'h0000_000a_0000_1800;

endpackage

//--- src/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
	input  logic             clk,
	input  logic             rst_n,
	input  rv_pkg::reg_idx_t rs1_idx,
	input  rv_pkg::reg_idx_t rs2_idx,
	output rv_pkg::xlen_t    rs1_data,
	output rv_pkg::xlen_t    rs2_data,
	input  logic             wen,
	input  rv_pkg::reg_idx_t rd,
	input  rv_pkg::xlen_t    wdata
);
	import rv_pkg::*;

	// x1 .. x31, x0 has no storage
	xlen_t regs [31:1];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 1; i < 32; i++) regs[i] <= '0;
		end else if (wen && rd != '0) begin
			regs[rd] <= wdata;
		end
	end

	// x0 reads as zero
	assign rs1_data = (rs1_idx == '0) ? '0 : regs[rs1_idx];
	assign rs2_data = (rs2_idx == '0) ? '0 : regs[rs2_idx];

endmodule

//--- src/rv_retire.sv
`timescale 1ns/1ps

module rv_retire (
	result_if.consumer       alu_res,
	result_if.consumer       csr_res,
	input  rv_pkg::xlen_t    ex_pc,
	output logic             rf_wen,
	output rv_pkg::reg_idx_t rf_rd,
	output rv_pkg::xlen_t    rf_wdata,
	output logic             redirect,
	output rv_pkg::xlen_t    redirect_pc,
	output logic             retire_valid,
	output rv_pkg::xlen_t    retire_pc,
	output logic             retire_wen,
	output rv_pkg::reg_idx_t retire_rd,
	output rv_pkg::xlen_t    retire_data
);
	import rv_pkg::*;

	logic sel_alu;

	// at most one unit owns the instruction
	assign sel_alu = alu_res.valid;

	// register write, x0 never reported as written
	assign rf_rd    = sel_alu ? alu_res.rd : csr_res.rd;
	assign rf_wdata = sel_alu ? alu_res.data : csr_res.data;
	assign rf_wen   = (sel_alu ? alu_res.wen : csr_res.wen) && rf_rd != '0;

	// redirect strobe to fetch
	assign redirect    = alu_res.redirect || csr_res.redirect;
	assign redirect_pc = alu_res.redirect ? alu_res.target : csr_res.target;

	// retire report for the checker
	assign retire_valid = alu_res.valid || csr_res.valid;
	assign retire_pc    = ex_pc;
	assign retire_wen   = rf_wen;
	assign retire_rd    = rf_rd;
	assign retire_data  = rf_wdata;

	// decode routes each instruction to exactly one unit
	one_owner: assert final (!(alu_res.valid === 1'b1 && csr_res.valid === 1'b1));

endmodule

//--- tests/rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb;
	import rv_pkg::*;

	localparam xlen_t base_pc      = 64'h8000_0000;
	localparam int    mem_words    = 256;
	localparam int    reset_cycles = 4;
	localparam inst_t nop          = 32'h0000_0013;

	logic     clk, rst_n;
	xlen_t    inst_addr, retire_pc, retire_data;
	inst_t    inst;
	logic     retire_valid, retire_wen;
	reg_idx_t retire_rd;

	inst_t mem [mem_words];
	int    n_inst, cycles, limit, errors, timing_errors, retired;
	logic  done, timed_out, started, bubble;

	// model state
	xlen_t m_x [32];
	xlen_t m_pc, m_mstatus, m_mtvec, m_mepc, m_mcause;

	rv_core #(.reset_pc(base_pc)) dut0 (.clk, .rst_n, .inst_addr, .inst, .retire_valid,
		.retire_pc, .retire_wen, .retire_rd, .retire_data);

	always #5 clk = ~clk;

	//****************************************
	// instruction memory and encoders
	//****************************************

	// outside the program reads as nop
	function automatic inst_t fetch_word(xlen_t addr);
		if (addr >= base_pc && addr < base_pc + 4 * mem_words && addr[1:0] == 2'b00)
			return mem[(addr - base_pc) >> 2];
		return nop;
	endfunction

	assign inst = fetch_word(inst_addr);

	function automatic inst_t enc_i(logic [6:0] opc, logic [2:0] f3, reg_idx_t rd,
		reg_idx_t rs1, logic [11:0] imm);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic inst_t enc_r(logic [6:0] f7, logic [2:0] f3, reg_idx_t rd,
		reg_idx_t rs1, reg_idx_t rs2);
		return {f7, rs2, rs1, f3, rd, 7'h33};
	endfunction

	function automatic inst_t enc_b(logic [2:0] f3, reg_idx_t rs1, reg_idx_t rs2,
		logic [12:0] off);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
	endfunction

	function automatic inst_t enc_u(logic [6:0] opc, reg_idx_t rd, logic [19:0] imm);
		return {imm, rd, opc};
	endfunction

	function automatic inst_t enc_j(reg_idx_t rd, logic [20:0] off);
		return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
	endfunction

	task automatic emit(input inst_t w);
		mem[n_inst] = w;
		n_inst++;
	endtask

	// random alu op on x0..x7 so dependences are dense
	function automatic inst_t rand_alu();
		int          kind;
		logic [31:0] r;
		reg_idx_t    rd, rs1, rs2;
		kind = $urandom_range(10, 0);
		r    = $urandom;
		rd   = r[4:0] & 5'd7;
		rs1  = r[9:5] & 5'd7;
		rs2  = r[14:10] & 5'd7;
		case (kind)
			0: return enc_i(7'h13, 3'b000, rd, rs1, r[31:20]);
			1: return enc_i(7'h13, 3'b111, rd, rs1, r[31:20]);
			2: return enc_i(7'h13, 3'b110, rd, rs1, r[31:20]);
			3: return enc_i(7'h13, 3'b100, rd, rs1, r[31:20]);
			4: return enc_r(7'h00, 3'b000, rd, rs1, rs2);
			5: return enc_r(7'h20, 3'b000, rd, rs1, rs2);
			6: return enc_r(7'h00, 3'b111, rd, rs1, rs2);
			7: return enc_r(7'h00, 3'b110, rd, rs1, rs2);
			8: return enc_r(7'h00, 3'b100, rd, rs1, rs2);
			9: return enc_u(7'h37, rd, r[31:12]);
			default: return enc_u(7'h17, rd, r[31:12]);
		endcase
	endfunction

	// taken branch skips the marker increment
	task automatic branch_case(input logic [2:0] f3, input reg_idx_t rs1, input reg_idx_t rs2);
		emit(enc_b(f3, rs1, rs2, 13'd8));
		emit(enc_i(7'h13, 3'b000, 10, 10, 12'd1));
	endtask

	//****************************************
	// program builder
	//****************************************

	task automatic build_program();
		int patch_idx, auipc_idx, handler_idx;
		logic [31:0] r;
		for (int i = 0; i < mem_words; i++) mem[i] = nop;
		n_inst = 0;
		for (int i = 0; i < 48; i++) emit(rand_alu());
		// signed edge operands
		emit(enc_i(7'h13, 3'b000, 1, 0, 12'hfff));
		emit(enc_i(7'h13, 3'b000, 2, 0, 12'h001));
		emit(enc_i(7'h13, 3'b000, 3, 0, 12'hfff));
		emit(enc_u(7'h37, 4, 20'h80000));
		branch_case(3'b000, 1, 3);
		branch_case(3'b000, 1, 2);
		branch_case(3'b001, 1, 2);
		branch_case(3'b001, 1, 3);
		branch_case(3'b100, 1, 2);
		branch_case(3'b100, 2, 1);
		branch_case(3'b100, 4, 1);
		branch_case(3'b101, 2, 1);
		branch_case(3'b101, 1, 2);
		branch_case(3'b101, 1, 3);
		// jal forward, then backward, then out
		emit(enc_j(5, 21'd12));
		emit(enc_j(0, 21'd12));
		emit(enc_i(7'h13, 3'b000, 10, 10, 12'd1));
		emit(enc_j(6, -21'sd8));
		// jalr with odd offset, bit 0 dropped
		emit(enc_u(7'h17, 7, 20'h0));
		emit(enc_i(7'h67, 3'b000, 8, 7, 12'd13));
		emit(enc_i(7'h13, 3'b000, 10, 10, 12'd1));
		// csr section
		emit(enc_i(7'h73, 3'b010, 11, 0, 12'h300));
		auipc_idx = n_inst;
		emit(enc_u(7'h17, 9, 20'h0));
		patch_idx = n_inst;
		emit(nop);
		emit(enc_i(7'h73, 3'b001, 12, 9, 12'h305));
		emit(enc_i(7'h73, 3'b010, 13, 0, 12'h305));
		r = $urandom;
		emit(enc_i(7'h13, 3'b000, 14, 0, r[11:0]));
		emit(enc_i(7'h73, 3'b001, 15, 14, 12'h341));
		emit(enc_i(7'h13, 3'b000, 17, 0, r[23:12]));
		emit(enc_i(7'h73, 3'b010, 18, 17, 12'h341));
		emit(enc_i(7'h73, 3'b010, 18, 0, 12'h341));
		// unknown csr
		emit(enc_i(7'h73, 3'b001, 19, 14, 12'h7c0));
		// set MIE so the trap has something to move
		emit(enc_i(7'h13, 3'b000, 23, 0, 12'd8));
		emit(enc_i(7'h73, 3'b010, 0, 23, 12'h300));
		emit(32'h0000_0073);
		emit(32'h0000_0000);
		// csrrwi is not supported
		emit(enc_i(7'h73, 3'b101, 5, 0, 12'h305));
		emit(enc_i(7'h73, 3'b010, 24, 0, 12'h300));
		emit(enc_j(0, 21'd0));
		// trap handler, returns past the trapping instruction
		handler_idx = n_inst;
		emit(enc_i(7'h73, 3'b010, 20, 0, 12'h342));
		emit(enc_i(7'h73, 3'b010, 21, 0, 12'h341));
		emit(enc_i(7'h73, 3'b010, 22, 0, 12'h300));
		emit(enc_i(7'h13, 3'b000, 21, 21, 12'd4));
		emit(enc_i(7'h73, 3'b001, 0, 21, 12'h341));
		emit(32'h3020_0073);
		mem[patch_idx] = enc_i(7'h13, 3'b000, 9, 9, 12'((handler_idx - auipc_idx) * 4));
	endtask

	//****************************************
	// ISA reference
	//****************************************

	function automatic xlen_t csr_read(logic [11:0] a);
		case (a)
			12'h300: return m_mstatus;
			12'h305: return m_mtvec;
			12'h341: return m_mepc;
			12'h342: return m_mcause;
			default: return '0;
		endcase
	endfunction

	function automatic void csr_write(logic [11:0] a, xlen_t v);
		case (a)
			12'h300: m_mstatus = v;
			12'h305: m_mtvec = v;
			12'h341: m_mepc = v;
			12'h342: m_mcause = v;
			default: ;
		endcase
	endfunction

	function automatic void ref_step(output xlen_t pc, output logic wen, output reg_idx_t rd,
		output xlen_t data, output xlen_t next_pc);
		inst_t      w;
		logic [2:0] f3;
		logic [6:0] f7;
		xlen_t      a, b, imm_i, imm_b, imm_u, imm_j, res, old;
		logic       wr, ill, taken;
		w     = fetch_word(m_pc);
		f3    = w[14:12];
		f7    = w[31:25];
		a     = m_x[w[19:15]];
		b     = m_x[w[24:20]];
		imm_i = {{52{w[31]}}, w[31:20]};
		imm_b = {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
		imm_u = {{32{w[31]}}, w[31:12], 12'b0};
		imm_j = {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
		pc      = m_pc;
		next_pc = m_pc + 4;
		wr      = 1'b0;
		ill     = 1'b0;
		taken   = 1'b0;
		res     = '0;
		case (w[6:0])
			7'h37: begin
				wr  = 1'b1;
				res = imm_u;
			end
			7'h17: begin
				wr  = 1'b1;
				res = m_pc + imm_u;
			end
			7'h6f: begin
				wr      = 1'b1;
				res     = m_pc + 4;
				next_pc = m_pc + imm_j;
			end
			7'h67: begin
				ill     = (f3 != 3'b000);
				wr      = !ill;
				res     = m_pc + 4;
				next_pc = (a + imm_i) & ~64'd1;
			end
			7'h63: begin
				case (f3)
					3'b000: taken = (a == b);
					3'b001: taken = (a != b);
					3'b100: taken = ($signed(a) < $signed(b));
					3'b101: taken = ($signed(a) >= $signed(b));
					default: ill = 1'b1;
				endcase
				if (taken) next_pc = m_pc + imm_b;
			end
			7'h13: begin
				wr = 1'b1;
				case (f3)
					3'b000: res = a + imm_i;
					3'b111: res = a & imm_i;
					3'b110: res = a | imm_i;
					3'b100: res = a ^ imm_i;
					default: ill = 1'b1;
				endcase
			end
			7'h33: begin
				wr = 1'b1;
				if (f7 == 7'h20 && f3 == 3'b000) res = a - b;
				else if (f7 != 7'h00) ill = 1'b1;
				else if (f3 == 3'b000) res = a + b;
				else if (f3 == 3'b111) res = a & b;
				else if (f3 == 3'b110) res = a | b;
				else if (f3 == 3'b100) res = a ^ b;
				else ill = 1'b1;
			end
			7'h73: begin
				if (f3 == 3'b001 || f3 == 3'b010) begin
					old = csr_read(w[31:20]);
					wr  = 1'b1;
					res = old;
					csr_write(w[31:20], (f3 == 3'b001) ? a : (old | a));
				end else if (w == 32'h0000_0073) begin
					m_mcause = 64'd11;
					m_mepc   = m_pc;
					m_mstatus[7] = m_mstatus[3];
					m_mstatus[3] = 1'b0;
					next_pc  = {m_mtvec[63:2], 2'b00};
				end else if (w == 32'h3020_0073) begin
					m_mstatus[3] = m_mstatus[7];
					m_mstatus[7] = 1'b1;
					next_pc  = {m_mepc[63:2], 2'b00};
				end else begin
					ill = 1'b1;
				end
			end
			default: ill = 1'b1;
		endcase
		// illegal instruction trap, cause 2
		if (ill) begin
			wr       = 1'b0;
			m_mcause = 64'd2;
			m_mepc   = m_pc;
			m_mstatus[7] = m_mstatus[3];
			m_mstatus[3] = 1'b0;
			next_pc  = {m_mtvec[63:2], 2'b00};
		end
		rd   = w[11:7];
		wen  = wr && rd != 5'd0;
		data = res;
		if (wen) m_x[rd] = res;
		m_pc = next_pc;
	endfunction

	//****************************************
	// compare tasks
	//****************************************

	task automatic check_word(input string name, input xlen_t got, input xlen_t exp);
		if (got !== exp) begin
			errors++;
			$display("FAIL %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_idx(input string name, input reg_idx_t got, input reg_idx_t exp);
		if (got !== exp) begin
			errors++;
			$display("FAIL %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			errors++;
			$display("FAIL %s got %h expected %h", name, got, exp);
		end
	endtask

	// sampled mid cycle, retire outputs settled
	always @(negedge clk) begin
		xlen_t    exp_pc, exp_data, next_pc;
		logic     exp_wen;
		reg_idx_t exp_rd;
		if (!rst_n) begin
			if (cycles > 0 && retire_valid !== 1'b0) begin
				timing_errors++;
				$display("retire_valid is active while reset is held");
			end
		end else if (!done && !timed_out) begin
			if (bubble) begin
				if (retire_valid) begin
					timing_errors++;
					$display("instruction after a control transfer retired at pc %h", retire_pc);
				end
				bubble = 1'b0;
			end else if (retire_valid) begin
				ref_step(exp_pc, exp_wen, exp_rd, exp_data, next_pc);
				check_word("retire_pc", retire_pc, exp_pc);
				check_bit("retire_wen", retire_wen, exp_wen);
				if (exp_wen) begin
					check_idx("retire_rd", retire_rd, exp_rd);
					check_word("retire_data", retire_data, exp_data);
				end
				started = 1'b1;
				retired++;
				bubble  = (next_pc != exp_pc + 4);
				// self loop reached
				if (next_pc == exp_pc) done = 1'b1;
			end else if (started) begin
				timing_errors++;
				$display("no retire in straight-line code, model pc %h", m_pc);
			end
		end
	end

	// run length guard
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= limit && !done) timed_out <= 1'b1;
	end

	initial begin
		void'($urandom(78675));
		clk           = 1'b0;
		rst_n         = 1'b0;
		cycles        = 0;
		errors        = 0;
		timing_errors = 0;
		retired       = 0;
		done          = 1'b0;
		timed_out     = 1'b0;
		started       = 1'b0;
		bubble        = 1'b0;
		build_program();
		limit = 2 * n_inst + reset_cycles + 20;
		for (int i = 0; i < 32; i++) m_x[i] = '0;
		m_pc      = base_pc;
		m_mstatus = mstatus_reset;
		m_mtvec   = '0;
		m_mepc    = '0;
		m_mcause  = '0;
		repeat (reset_cycles) @(posedge clk);
		rst_n <= 1'b1;
		wait (done || timed_out);
		@(posedge clk);
		if (timed_out) $display("run did not reach the final loop within %0d cycles", limit);
		$display("retired %0d, value errors %0d, timing errors %0d, timeouts %0d",
			retired, errors, timing_errors, timed_out);
		if (errors == 0 && timing_errors == 0 && !timed_out) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule
